/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // fetch addresses
    localparam logic [31:0] boot_vector = 32'hbfc0_0000;  // first fetch after reset
    localparam logic [31:0] exc_vector  = 32'hbfc0_0380;  // exception entry point

    // instruction memory geometry
    localparam int imem_addr_bits = 8;                     // word index is pc[9:2]
    localparam int imem_words     = 1 << imem_addr_bits;  // 256 words

    // fetch queue toward decode
    localparam int fetch_queue_depth = 4;  // entries including the head
    localparam int q_count_bits      = 3;  // holds 0..fetch_queue_depth

    // decode input buffer size, granted as credits after reset
    localparam int ds_credits = 2;

    // cp0 style exception codes carried with each entry
    typedef enum logic [4:0] {
        exc_adel = 5'h04,  // address error on fetch
        exc_none = 5'h1f   // no exception
    } exc_code_e;

    // fetch controller states
    typedef enum logic [0:0] {
        st_run  = 1'b0,  // issuing sequentially
        st_halt = 1'b1   // misaligned fetch seen and waiting for redirect
    } fetch_state_e;

endpackage

`default_nettype wire

/* pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
    input  wire         clk,
    input  wire         reset,
    input  wire         br_taken,         // from decode
    input  wire  [31:0] br_target,
    input  wire         flush,            // exception from writeback
    input  wire         eret,             // exception return from writeback
    input  wire  [31:0] cp0_epc,
    input  wire         issue,            // fetch accepted this cycle
    output logic [31:0] next_pc,
    output logic        redirect,
    output logic        next_misaligned
);

    logic [31:0] pc;           // pc of the last issued fetch
    logic [31:0] seq_pc;
    logic        issued_once;  // first issue after reset done

    assign seq_pc   = pc + 32'd4;  // next word
    assign redirect = eret | flush | br_taken;

    // eret beats flush beats branch beats sequential
    assign next_pc = eret     ? cp0_epc :
                     flush    ? fetch_pkg::exc_vector :
                     br_taken ? br_target :
                                seq_pc;

    assign next_misaligned = |next_pc[1:0];  // word fetch only

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= fetch_pkg::boot_vector - 32'd4;  // so next_pc is boot vector
            issued_once <= 1'b0;
        end else if (issue) begin
            pc          <= next_pc;
            issued_once <= 1'b1;
        end
    end

    // the reset value of pc is only a residue for the first sequential step
    // and must be replaced by a fetch right after the first cycle out of reset
    a_residue_cleared : assert property (
        @(posedge clk) disable iff (reset)
        (!issued_once && !$past(reset)) |-> issue
    );

endmodule

`default_nettype wire

/* inst_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_sram (
    input  wire                                 clk,
    input  wire                                 rd_en,    // read strobe from fetch
    input  wire  [31:0]                         rd_addr,  // byte address
    input  wire                                 we,       // load port
    input  wire  [fetch_pkg::imem_addr_bits-1:0] waddr,   // word index
    input  wire  [31:0]                         wdata,
    output logic [31:0]                         rd_data   // valid cycle after rd_en
);

    logic [31:0] mem [fetch_pkg::imem_words];  // 256 x 32

    // whole word writes from the load port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read that holds the last word when idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr[fetch_pkg::imem_addr_bits+1:2]];  // pc[9:2]
        end
    end

    // misaligned fetches are turned into adel entries upstream
    // and must never reach the array
    a_rd_aligned : assert property (
        @(posedge clk) rd_en |-> (rd_addr[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

/* fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  push,
    input  wire  [31:0]                          push_pc,
    input  wire  [31:0]                          push_inst,
    input  var   fetch_pkg::exc_code_e           push_exc,
    input  wire                                  pop,
    input  wire                                  qflush,      // wins over push
    output logic [fetch_pkg::q_count_bits-1:0]   q_count,     // entries incl head
    output logic                                 head_valid,
    output logic [31:0]                          head_pc,
    output logic [31:0]                          head_inst,
    output fetch_pkg::exc_code_e                 head_exc
);

    localparam int depth    = fetch_pkg::fetch_queue_depth;
    localparam int ptr_bits = $clog2(depth);

    logic [31:0]          pc_mem   [depth];
    logic [31:0]          inst_mem [depth];
    fetch_pkg::exc_code_e exc_mem  [depth];

    logic [ptr_bits-1:0]                wr_ptr;
    logic [ptr_bits-1:0]                rd_ptr;
    logic [ptr_bits-1:0]                rd_ptr_nxt;
    logic [fetch_pkg::q_count_bits-1:0] count;
    logic [fetch_pkg::q_count_bits-1:0] count_after_pop;
    logic                               do_push;
    logic                               do_pop;

    assign do_push         = push & ~qflush;               // flush drops the push
    assign do_pop          = pop & head_valid & ~qflush;
    assign rd_ptr_nxt      = do_pop ? rd_ptr + 1'b1 : rd_ptr;
    assign count_after_pop = count - {{(fetch_pkg::q_count_bits-1){1'b0}}, do_pop};
    assign q_count         = count;

    // pointers, count and head flag
    always_ff @(posedge clk) begin
        if (reset || qflush) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            head_valid <= 1'b0;  // empty in one cycle
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps since depth is a power of two
            end
            rd_ptr     <= rd_ptr_nxt;
            count      <= count_after_pop + {{(fetch_pkg::q_count_bits-1){1'b0}}, do_push};
            head_valid <= (count_after_pop != '0) | do_push;
        end
    end

    // ring storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr]   <= push_pc;
            inst_mem[wr_ptr] <= push_inst;
            exc_mem[wr_ptr]  <= push_exc;
        end
    end

    // registered head holding a copy of the new front entry
    always_ff @(posedge clk) begin
        if (count_after_pop == '0) begin
            head_pc   <= push_pc;  // incoming entry goes straight to an empty head
            head_inst <= push_inst;
            head_exc  <= push_exc;
        end else begin
            head_pc   <= pc_mem[rd_ptr_nxt];
            head_inst <= inst_mem[rd_ptr_nxt];
            head_exc  <= exc_mem[rd_ptr_nxt];
        end
    end

    // the controller reserves a slot for every read it issues
    a_no_push_full : assert property (
        @(posedge clk) disable iff (reset)
        push |-> (int'(count) < depth)
    );

    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (reset)
        pop |-> head_valid
    );

endmodule

`default_nettype wire

/* fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                redirect,         // any redirect this cycle
    input  wire                                next_misaligned,
    input  wire  [fetch_pkg::q_count_bits-1:0] q_count,
    input  wire                                head_valid,
    input  wire                                ds_credit,        // one slot freed in decode
    input  wire  [31:0]                        rd_data,          // word from inst_sram
    input  wire  [31:0]                        next_pc,
    output logic                               issue,
    output logic                               rd_en,
    output logic                               push,
    output logic [31:0]                        push_pc,
    output logic [31:0]                        push_inst,
    output fetch_pkg::exc_code_e               push_exc,
    output logic                               pop,
    output logic                               qflush,
    output logic                               fs_valid
);

    localparam int credit_bits = $clog2(fetch_pkg::ds_credits + 1);

    fetch_pkg::fetch_state_e            state;
    logic                               out_of_reset;  // first cycle after reset
    logic [credit_bits-1:0]             credits;       // free decode slots
    logic [fetch_pkg::q_count_bits-1:0] occupancy;     // queued plus in flight
    logic                               room;

    // one-deep in-flight read
    logic        infl_valid;
    logic [31:0] infl_pc;
    logic        infl_mis;  // misaligned, no memory read done

    assign occupancy = q_count + {{(fetch_pkg::q_count_bits-1){1'b0}}, infl_valid};
    assign room      = int'(occupancy) < fetch_pkg::fetch_queue_depth;

    // redirect forces a fetch at the new target
    assign issue = out_of_reset &
                   (redirect | ((state == fetch_pkg::st_run) & room));
    assign rd_en = issue & ~next_misaligned;  // bad address never reads memory

    // in-flight entry lands in the queue unless a redirect kills it
    assign push      = infl_valid & ~redirect;
    assign push_pc   = infl_pc;
    assign push_inst = infl_mis ? 32'h0 : rd_data;
    assign push_exc  = infl_mis ? fetch_pkg::exc_adel : fetch_pkg::exc_none;
    assign qflush    = redirect;  // drop everything not yet delivered

    // deliver head when decode has room and no redirect is active
    assign fs_valid = head_valid & (credits != '0) & ~redirect;
    assign pop      = fs_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= fetch_pkg::st_run;
            out_of_reset <= 1'b0;
            credits      <= credit_bits'(fetch_pkg::ds_credits);  // decode buffer size
            infl_valid   <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
            if (issue) begin
                // halt after a misaligned fetch until the next redirect
                state <= next_misaligned ? fetch_pkg::st_halt : fetch_pkg::st_run;
            end
            credits    <= credits - credit_bits'(fs_valid) + credit_bits'(ds_credit);
            infl_valid <= issue;
        end
    end

    // in-flight payload
    always_ff @(posedge clk) begin
        if (issue) begin
            infl_pc  <= next_pc;
            infl_mis <= next_misaligned;
        end
    end

    // decode never returns more credits than it was given
    a_credit_bound : assert property (
        @(posedge clk) disable iff (reset)
        int'(credits) <= fetch_pkg::ds_credits
    );

endmodule

`default_nettype wire

/* fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  wire                                 clk,
    input  wire                                 reset,
    // redirects
    input  wire                                 br_taken,
    input  wire  [31:0]                         br_target,
    input  wire                                 flush,
    input  wire                                 eret,
    input  wire  [31:0]                         cp0_epc,
    // decode side
    output logic                                fs_valid,
    output logic [31:0]                         fs_pc,
    output logic [31:0]                         fs_inst,
    output logic                                fs_ex,
    output fetch_pkg::exc_code_e                fs_exc_code,
    input  wire                                 ds_credit,
    // program load
    input  wire                                 imem_we,
    input  wire  [fetch_pkg::imem_addr_bits-1:0] imem_waddr,
    input  wire  [31:0]                         imem_wdata
);

    logic [31:0]                        next_pc;
    logic                               redirect;
    logic                               next_misaligned;
    logic                               issue;
    logic                               rd_en;
    logic [31:0]                        rd_data;
    logic                               push;
    logic [31:0]                        push_pc;
    logic [31:0]                        push_inst;
    fetch_pkg::exc_code_e               push_exc;
    logic                               pop;
    logic                               qflush;
    logic [fetch_pkg::q_count_bits-1:0] q_count;
    logic                               head_valid;

    pc_gen pc_gen_i (
        .clk             (clk),
        .reset           (reset),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .flush           (flush),
        .eret            (eret),
        .cp0_epc         (cp0_epc),
        .issue           (issue),
        .next_pc         (next_pc),
        .redirect        (redirect),
        .next_misaligned (next_misaligned)
    );

    inst_sram inst_sram_i (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_addr (next_pc),
        .we      (imem_we),
        .waddr   (imem_waddr),
        .wdata   (imem_wdata),
        .rd_data (rd_data)
    );

    fetch_queue fetch_queue_i (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_pc    (push_pc),
        .push_inst  (push_inst),
        .push_exc   (push_exc),
        .pop        (pop),
        .qflush     (qflush),
        .q_count    (q_count),
        .head_valid (head_valid),
        .head_pc    (fs_pc),        // head drives decode directly
        .head_inst  (fs_inst),
        .head_exc   (fs_exc_code)
    );

    fetch_ctrl fetch_ctrl_i (
        .clk             (clk),
        .reset           (reset),
        .redirect        (redirect),
        .next_misaligned (next_misaligned),
        .q_count         (q_count),
        .head_valid      (head_valid),
        .ds_credit       (ds_credit),
        .rd_data         (rd_data),
        .next_pc         (next_pc),
        .issue           (issue),
        .rd_en           (rd_en),
        .push            (push),
        .push_pc         (push_pc),
        .push_inst       (push_inst),
        .push_exc        (push_exc),
        .pop             (pop),
        .qflush          (qflush),
        .fs_valid        (fs_valid)
    );

    assign fs_ex = (fs_exc_code != fetch_pkg::exc_none);  // any exception on the entry

endmodule

`default_nettype wire

/* fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

    localparam int max_wait    = 60;  // cycles allowed per entry
    localparam int halt_window = 8;   // quiet cycles checked after an adel entry

    logic                 clk;
    logic                 reset;
    logic                 br_taken;
    logic [31:0]          br_target;
    logic                 flush;
    logic                 eret;
    logic [31:0]          cp0_epc;
    logic                 ds_credit;
    logic                 imem_we;
    logic [7:0]           imem_waddr;
    logic [31:0]          imem_wdata;
    wire                  fs_valid;
    wire  [31:0]          fs_pc;
    wire  [31:0]          fs_inst;
    wire                  fs_ex;
    fetch_pkg::exc_code_e fs_exc_code;

    logic [31:0] image [fetch_pkg::imem_words];  // reference copy of the program
    int          seg_kind [$];                   // 1 branch, 2 flush, 4 eret
    logic [31:0] seg_target [$];
    logic [31:0] seg_epc [$];
    int          seg_count [$];
    int          due [$];                        // cycles at which decode frees a slot

    logic [19:0] lfsr_state;
    int          cycle_no;
    int          delivered;
    int          returned;
    int          checked;
    int          mismatches;
    int          timeouts;
    int          other_errs;
    bit          abort;

    bit          redir_pending;  // redirect to drive next cycle
    int          redir_kind;
    logic [31:0] redir_target;
    logic [31:0] redir_epc;

    bit                   got;  // delivery seen this cycle
    logic [31:0]          got_pc;
    logic [31:0]          got_inst;
    bit                   got_ex;
    fetch_pkg::exc_code_e got_code;

    fetch_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .flush       (flush),
        .eret        (eret),
        .cp0_epc     (cp0_epc),
        .fs_valid    (fs_valid),
        .fs_pc       (fs_pc),
        .fs_inst     (fs_inst),
        .fs_ex       (fs_ex),
        .fs_exc_code (fs_exc_code),
        .ds_credit   (ds_credit),
        .imem_we     (imem_we),
        .imem_waddr  (imem_waddr),
        .imem_wdata  (imem_wdata)
    );

    always #50 clk = ~clk;  // 100 ns period

    // maximal length taps x^20 + x^17 + 1
    function automatic logic [19:0] lfsr_next(input logic [19:0] s);
        return {s[18:0], s[19] ^ s[16]};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);       // one step per bit
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // background content with every word distinct
    function automatic logic [31:0] fill_word(input int idx);
        logic [7:0] w;
        w = idx[7:0];
        return {8'h24, w, ~w, w};
    endfunction

    // eret over flush over branch over the boot vector
    function automatic logic [31:0] seg_start(input int s);
        if (seg_kind[s] & 4) return seg_epc[s];
        if (seg_kind[s] & 2) return fetch_pkg::exc_vector;
        if (seg_kind[s] & 1) return seg_target[s];
        return fetch_pkg::boot_vector;
    endfunction

    // drive just after the edge and sample at the falling edge
    task automatic next_cycle();
        int idx;
        int d;
        @(posedge clk);
        #1;
        cycle_no++;
        idx       = -1;
        ds_credit = 1'b0;
        foreach (due[q]) begin
            if (idx < 0 && due[q] <= cycle_no) idx = q;  // one slot per cycle
        end
        if (idx >= 0) begin
            ds_credit = 1'b1;
            due.delete(idx);
            returned++;
        end
        br_taken = redir_pending && redir_kind[0];
        flush    = redir_pending && redir_kind[1];
        eret     = redir_pending && redir_kind[2];
        if (redir_pending) begin
            br_target = redir_target;
            cp0_epc   = redir_epc;
        end
        redir_pending = 1'b0;  // one cycle pulse
        @(negedge clk);
        got = fs_valid;
        if (fs_valid) begin
            got_pc   = fs_pc;
            got_inst = fs_inst;
            got_ex   = fs_ex;
            got_code = fs_exc_code;
            delivered++;
            take_bits(2, d);                  // 0..3 extra cycles in decode
            due.push_back(cycle_no + 1 + d);
            assert (delivered - returned <= fetch_pkg::ds_credits) else begin
                other_errs++;
                $display("decode overrun at %0t: %0d entries held, buffer holds %0d",
                         $time, delivered - returned, fetch_pkg::ds_credits);
            end
        end
    endtask

    task automatic check_entry(input logic [31:0] exp_pc);
        bit exp_ex;
        exp_ex = (exp_pc[1:0] != 2'b00);
        checked++;
        assert (got_pc == exp_pc) else begin
            mismatches++;
            $display("mismatch at %0t: fs_pc %h, expected %h", $time, got_pc, exp_pc);
        end
        assert (got_ex == exp_ex) else begin
            mismatches++;
            $display("mismatch at %0t: fs_ex %0b at pc %h", $time, got_ex, exp_pc);
        end
        if (exp_ex) begin
            assert (got_code == fetch_pkg::exc_adel) else begin
                mismatches++;
                $display("mismatch at %0t: code %h, expected adel", $time, got_code);
            end
        end else begin
            assert (got_code == fetch_pkg::exc_none) else begin
                mismatches++;
                $display("mismatch at %0t: code %h, expected none", $time, got_code);
            end
            assert (got_inst == image[exp_pc[9:2]]) else begin
                mismatches++;
                $display("mismatch at %0t: inst %h at pc %h, expected %h",
                         $time, got_inst, exp_pc, image[exp_pc[9:2]]);
            end
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          kind;
        int          k;
        int          waited;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] t;
        logic [31:0] e;
        logic [31:0] start;
        logic [31:0] pc;
        clk           = 1'b0;
        reset         = 1'b1;
        br_taken      = 1'b0;
        br_target     = 32'h0;
        flush         = 1'b0;
        eret          = 1'b0;
        cp0_epc       = 32'h0;
        ds_credit     = 1'b0;
        imem_we       = 1'b0;
        imem_waddr    = 8'h0;
        imem_wdata    = 32'h0;
        lfsr_state    = 20'd73478;
        redir_pending = 1'b0;
        pc            = 32'h0;
        for (int i = 0; i < fetch_pkg::imem_words; i++) image[i] = fill_word(i);
        fd = $fopen("fetch_testdata.txt", "r");
        if (fd == 0) begin
            other_errs++;
            abort = 1'b1;
            $display("cannot open fetch_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (line.len() > 0 && line.getc(0) == "M") begin
                    n = $sscanf(line, "M %h %h", a, d);
                    if (n == 2) image[a[7:0]] = d;  // program word over the fill
                end else if (line.len() > 0 && line.getc(0) == "S") begin
                    n = $sscanf(line, "S %h %h %h %d", kind, t, e, k);
                    if (n == 4) begin
                        seg_kind.push_back(kind);
                        seg_target.push_back(t);
                        seg_epc.push_back(e);
                        seg_count.push_back(k);
                    end
                end
            end
            $fclose(fd);
        end
        // program load with the core held in reset
        for (int i = 0; i < fetch_pkg::imem_words; i++) begin
            @(posedge clk);
            #1;
            imem_we    = 1'b1;
            imem_waddr = i[7:0];
            imem_wdata = image[i];
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
        repeat (2) begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;
        for (int s = 0; s < seg_count.size() && !abort; s++) begin
            start = seg_start(s);
            if (s > 0) begin
                redir_pending = 1'b1;  // right after the last entry of the previous segment
                redir_kind    = seg_kind[s];
                redir_target  = seg_target[s];
                redir_epc     = seg_epc[s];
            end
            for (int i = 0; i < seg_count[s] && !abort; i++) begin
                pc     = start + 32'(4 * i);
                got    = 1'b0;
                waited = 0;
                while (!got && waited < max_wait) begin
                    next_cycle();
                    waited++;
                end
                if (!got) begin
                    timeouts++;
                    abort = 1'b1;
                    $display("timeout at %0t: entry %0d of segment %0d never arrived",
                             $time, i, s);
                end else begin
                    check_entry(pc);
                end
            end
            // misaligned fetch halts the front end until the next redirect
            if (!abort && pc[1:0] != 2'b00) begin
                for (int j = 0; j < halt_window; j++) begin
                    next_cycle();
                    assert (!got) else begin
                        other_errs++;
                        $display("delivery at %0t while halted after an address error", $time);
                    end
                end
            end
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d other; %0d entries checked",
                 mismatches, timeouts, other_errs, checked);
        if (mismatches + timeouts + other_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_testdata.txt */
# M <word index, hex> <instruction word, hex>, written over a fill pattern
# S <redirect mask, hex: 1 branch 2 flush 4 eret> <br_target> <cp0_epc> <entry count, dec>
M 00 3c1dbfc0
M 01 27bd1000
M 02 3c08a000
M 03 25080100
M 04 8d090000
M 05 11200004
M 06 00000000
M 40 24020001
M 41 24030002
M 42 00431020
M 43 ac020000
M 44 1000fffb
M 80 03e00008
M 81 27bd0020
M 82 8fbf001c
M e0 401a6800
M e1 401b7000
M e2 42000018
M fe 3c1a8000
M ff 375a0180
S 0 00000000 00000000 6
S 1 bfc00100 00000000 5
S 6 bfc00040 bfc00200 4
S 3 bfc00040 00000000 4
S 1 bfc00122 00000000 1
S 1 bfc000f0 00000000 8
S 5 bfc00010 bfc003f8 5
S 2 00000000 00000000 12
S 4 00000000 bfc00002 1
S 1 bfc00000 00000000 10

/* all.f */
fetch_pkg.sv
pc_gen.sv
inst_sram.sv
fetch_queue.sv
fetch_ctrl.sv
fetch_top.sv
fetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fetch_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Simulation passed" $(LOG) || (echo "check $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
